/* bench/tb_vmask_ref.svh */
// iota reference model
`ifndef TB_VMASK_REF_SVH
`define TB_VMASK_REF_SVH

// marker held by result bytes that no write touches.
function automatic logic [7:0] fill_byte(input int addr);
  return 8'(addr * 37 + 91); // odd step, distinct over all 256 bytes.
endfunction

// expected 32-word result image and byte enables for one viota.m run.
function automatic void iota_expect(input  logic [63:0]   mask,
                                    input  int            vl,
                                    input  int            esz,
                                    output logic [2047:0] img,
                                    output logic [255:0]  en);
  int          cnt;
  logic [31:0] val;
  cnt = 0;
  for (int a = 0; a < 256; a++) begin
    img[8*a +: 8] = fill_byte(a); // tail bytes keep the marker.
    en[a]         = 1'b0;
  end
  for (int i = 0; i < vl; i++) begin
    val = 32'(cnt); // set mask bits strictly below element i.
    for (int k = 0; k < esz; k++) begin
      img[8*(i*esz + k) +: 8] = val[8*k +: 8]; // little endian, cut to esz bytes.
      en[i*esz + k]           = 1'b1;
    end
    if (mask[i]) begin
      cnt++;
    end
  end
endfunction

`endif

/* bench/tb_vmask_unit.sv */
// viota.m mask unit testbench

module tb_vmask_unit;
  import rv32v_types_pkg::*;

  localparam int RUN_LIMIT = 200; // cycles allowed for one run.

  logic                  CLK;
  logic                  nRST;
  logic                  cfg_we;
  logic [CFG_ADDR_W-1:0] cfg_addr;
  logic [31:0]           cfg_wdata;
  logic [31:0]           cfg_rdata;
  logic                  done;
  logic                  res_we;
  logic [WORD_IDX_W-1:0] res_idx;
  logic [WORD_W-1:0]     res_data;
  logic [7:0]            res_be;

  logic [7:0]   img_cap [256]; // captured result bytes, 32 words.
  logic [255:0] wrote;         // bytes hit by an enabled write.
  int           wr_cnt   = 0;  // res_we pulses seen.
  int           done_cnt = 0;  // done pulses seen.
  int           run_id   = 0;  // bumped by the stimulus for each run.
  int           seen_id  = 0;  // last run the capture image was cleared for.
  int           data_errs;
  int           be_errs;
  int           ctl_errs;
  int           timeouts;
  integer       seed;

  `include "tb_vmask_ref.svh"

  vmask_unit UUT (
    .CLK       (CLK),
    .nRST      (nRST),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .done      (done),
    .res_we    (res_we),
    .res_idx   (res_idx),
    .res_data  (res_data),
    .res_be    (res_be)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // result sink, one word per cycle under res_be.
  always @(posedge CLK) begin
    if (run_id != seen_id) begin // new run, restore the marker image.
      seen_id = run_id;
      wrote   = '0;
      for (int a = 0; a < 256; a++) begin
        img_cap[a] = fill_byte(a);
      end
    end
    if (res_we) begin
      wr_cnt++;
      for (int b = 0; b < 8; b++) begin
        if (res_be[b]) begin
          img_cap[int'(res_idx) * 8 + b] = res_data[8*b +: 8];
          wrote[int'(res_idx) * 8 + b]   = 1'b1;
        end
      end
    end
    if (done) begin
      done_cnt++;
    end
  end

  task automatic reg_write(input logic [CFG_ADDR_W-1:0] addr, input logic [31:0] data);
    @(negedge CLK);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(negedge CLK);
    cfg_we    = 1'b0; // one-cycle strobe.
  endtask

  task automatic reg_read(input logic [CFG_ADDR_W-1:0] addr, output logic [31:0] data);
    @(negedge CLK);
    cfg_addr = addr;
    @(negedge CLK);
    data = cfg_rdata; // address held a full cycle.
  endtask

  // byte by byte against the reference image.
  task automatic compare_image(input logic [2047:0] exp_img, input logic [255:0] exp_en);
    for (int a = 0; a < 256; a++) begin
      if (img_cap[a] !== exp_img[8*a +: 8]) begin
        data_errs++;
        $display("error t=%0t res_data byte %0d: got %h expected %h",
                 $time, a, img_cap[a], exp_img[8*a +: 8]);
      end
      if (wrote[a] !== exp_en[a]) begin
        be_errs++;
        $display("error t=%0t res_be byte %0d: got %b expected %b",
                 $time, a, wrote[a], exp_en[a]);
      end
    end
  endtask

  // load config, start, wait for done and check the image.
  task automatic run_case(input logic [63:0] mask, input int vl_req, input int sew_code,
                          input logic poke);
    logic [2047:0] exp_img;
    logic [255:0]  exp_en;
    logic [31:0]   rd;
    int            vl_eff;
    int            esz;
    int            words;
    int            wr0;
    int            done0;
    int            n;
    if (timeouts != 0) begin
      return;
    end
    vl_eff = (vl_req > MASK_BITS) ? MASK_BITS : vl_req; // unit clamps vl.
    esz    = 1 << sew_code;                             // 1, 2 or 4 bytes.
    words  = (vl_eff * esz + 7) / 8;
    run_id++;
    reg_write(REG_MASK_LO, mask[31:0]);
    reg_write(REG_MASK_HI, mask[63:32]);
    reg_write(REG_SEW, sew_code);
    reg_write(REG_VL, vl_req);
    wr0   = wr_cnt;
    done0 = done_cnt;
    reg_write(REG_CTRL, 32'd1);
    if (poke) begin
      reg_read(REG_STATUS, rd);
      if (rd[ST_BUSY] !== 1'b1) begin
        ctl_errs++;
        $display("error t=%0t cfg_rdata busy during run: got %b expected 1", $time,
                 rd[ST_BUSY]);
      end
      reg_write(REG_CTRL, 32'd1); // lands mid-run, dropped.
    end
    n = 0;
    while (done_cnt == done0 && n < RUN_LIMIT) begin
      @(negedge CLK);
      n++;
    end
    if (done_cnt == done0) begin
      timeouts++;
      $display("timeout: no done pulse within %0d cycles of the start write", RUN_LIMIT);
      return;
    end
    repeat (4) @(negedge CLK); // room for a stray write or a second done.
    reg_read(REG_STATUS, rd);
    if (rd[ST_BUSY] !== 1'b0) begin
      ctl_errs++;
      $display("error t=%0t cfg_rdata busy after done: got %b expected 0", $time,
               rd[ST_BUSY]);
    end
    if (done_cnt - done0 != 1) begin
      ctl_errs++;
      $display("error t=%0t done pulses: got %0d expected 1", $time, done_cnt - done0);
    end
    if (wr_cnt - wr0 != words) begin
      ctl_errs++;
      $display("error t=%0t res_we writes: got %0d expected %0d", $time, wr_cnt - wr0, words);
    end
    iota_expect(mask, vl_eff, esz, exp_img, exp_en);
    compare_image(exp_img, exp_en);
  endtask

  initial begin
    logic [63:0] rmask;
    int          rvl;
    int          rsew;
    nRST      = 1'b0;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    data_errs = 0;
    be_errs   = 0;
    ctl_errs  = 0;
    timeouts  = 0;
    seed      = 32'hb2bb;
    repeat (8) @(negedge CLK);
    nRST = 1'b1;
    if (done !== 1'b0 || res_we !== 1'b0) begin
      ctl_errs++;
      $display("error t=%0t done/res_we after reset: got %b/%b expected 0/0", $time,
               done, res_we);
    end

    // full length at each width.
    for (int s = 0; s < 3; s++) begin
      run_case(64'h8f3c_0a51_f00d_7e29, 64, s, 1'b0);
    end
    // tails that end inside a word.
    run_case(64'hffff_ffff_ffff_ffff, 13, 1, 1'b0);
    run_case(64'h5555_aaaa_0f0f_3333, 13, 0, 1'b0);
    run_case(64'h0123_4567_89ab_cdef, 5, 2, 1'b0);
    run_case(64'hdead_0000_beef_ffff, 90, 0, 1'b0); // clamps to 64.
    // corner masks.
    for (int s = 0; s < 3; s++) begin
      run_case(64'h0, 64, s, 1'b0);
      run_case(64'hffff_ffff_ffff_ffff, 64, s, 1'b0);
      run_case(64'h8000_0000_0000_0000, 64, s, 1'b0);
    end
    run_case(64'hffff_0000_ffff_0000, 0, 1, 1'b0);  // empty run.
    run_case(64'h7654_3210_fedc_ba98, 64, 2, 1'b1); // status and mid-run ctrl.

    for (int r = 0; r < 200; r++) begin
      rmask = {$random(seed), $random(seed)};
      rvl   = $unsigned($random(seed)) % 65;
      rsew  = $unsigned($random(seed)) % 3;
      run_case(rmask, rvl, rsew, 1'b0);
    end

    $display("summary: %0d data errors, %0d enable errors, %0d control errors, %0d timeouts",
             data_errs, be_errs, ctl_errs, timeouts);
    if (data_errs + be_errs + ctl_errs + timeouts == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* design/iota_logic.sv */
// iota prefix count datapath

module iota_logic (
  input  logic                                  CLK,
  input  logic                                  nRST,
  input  logic                                  start,
  input  logic [rv32v_types_pkg::MASK_BITS-1:0] mask_bits,
  input  rv32v_types_pkg::sew_t                 sew,
  input  logic [rv32v_types_pkg::CNT_W-1:0]     max,
  output logic                                  busy,
  output logic [rv32v_types_pkg::HALF_W-1:0]    res0,
  output logic [rv32v_types_pkg::HALF_W-1:0]    res1
);
  import rv32v_types_pkg::*;

  logic [MASK_BITS-1:0] mask_reg;       // remaining mask, lowest element at bit 0.
  logic [MASK_BITS-1:0] next_mask_reg;
  logic [MASK_BITS-1:0] cur_mask;       // mask view for this chunk.
  logic [CNT_W-1:0]     count;          // element position of chunk start.
  logic [CNT_W-1:0]     next_count;
  logic [CNT_W-1:0]     prev_res;       // prefix count of last element done.
  logic [CNT_W-1:0]     next_prev_res;
  logic                 prev_mask;      // mask bit of last element done.
  logic                 next_prev_mask;
  logic                 at_max;         // run has covered all chunks.
  logic [CNT_W-1:0]     pfx [8];        // prefix counts for up to 8 elements.

  // first chunk reads the mask straight from the config block.
  assign cur_mask = (count == '0) ? mask_bits : mask_reg;
  assign at_max   = (count == max) || (count == CNT_W'(MASK_BITS)); // 64 as backstop.
  assign busy     = start && !at_max;

  // adder chain, element j adds the mask bit of element j-1.
  always_comb begin : prefix_chain
    pfx[0] = (count == '0) ? '0 : prev_res + {{(CNT_W - 1){1'b0}}, prev_mask};
    for (int j = 1; j < 8; j++) begin
      pfx[j] = pfx[j-1] + {{(CNT_W - 1){1'b0}}, cur_mask[j-1]};
    end
  end

  always_comb begin
    res0           = '0;
    res1           = '0;
    next_mask_reg  = mask_reg;
    next_count     = count;
    next_prev_res  = prev_res;
    next_prev_mask = prev_mask;
    if (start) begin
      case (sew)
        SEW32: begin // 2 lanes of 32 bits.
          res0           = HALF_W'(pfx[0]);
          res1           = HALF_W'(pfx[1]);
          next_mask_reg  = cur_mask >> 2;
          next_count     = count + CNT_W'(2);
          next_prev_res  = pfx[1];
          next_prev_mask = cur_mask[1];
        end
        SEW16: begin // 4 lanes of 16 bits.
          res0           = {16'(pfx[1]), 16'(pfx[0])};
          res1           = {16'(pfx[3]), 16'(pfx[2])};
          next_mask_reg  = cur_mask >> 4;
          next_count     = count + CNT_W'(4);
          next_prev_res  = pfx[3];
          next_prev_mask = cur_mask[3];
        end
        default: begin // 8 lanes of 8 bits.
          res0           = {8'(pfx[3]), 8'(pfx[2]), 8'(pfx[1]), 8'(pfx[0])};
          res1           = {8'(pfx[7]), 8'(pfx[6]), 8'(pfx[5]), 8'(pfx[4])};
          next_mask_reg  = cur_mask >> 8;
          next_count     = count + CNT_W'(8);
          next_prev_res  = pfx[7];
          next_prev_mask = cur_mask[7];
        end
      endcase
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mask_reg  <= '0;
      count     <= '0;
      prev_res  <= '0;
      prev_mask <= 1'b0;
    end else if (at_max) begin // run over, ready for the next start.
      mask_reg  <= '0;
      count     <= '0;
      prev_res  <= '0;
      prev_mask <= 1'b0;
    end else begin
      mask_reg  <= next_mask_reg;
      count     <= next_count;
      prev_res  <= next_prev_res;
      prev_mask <= next_prev_mask;
    end
  end

  // max from the config block is chunk aligned, so count lands on it.
  a_count_range: assert property (@(posedge CLK) disable iff (!nRST)
    count <= CNT_W'(MASK_BITS));

endmodule

/* design/iota_result_writer.sv */
// iota result word writer

module iota_result_writer (
  input  logic                                   CLK,
  input  logic                                   nRST,
  input  logic                                   start,
  input  logic                                   busy,
  input  rv32v_types_pkg::sew_t                  sew,
  input  logic [rv32v_types_pkg::CNT_W-1:0]      vl,
  input  logic [rv32v_types_pkg::HALF_W-1:0]     res0,
  input  logic [rv32v_types_pkg::HALF_W-1:0]     res1,
  output logic                                   res_we,
  output logic [rv32v_types_pkg::WORD_IDX_W-1:0] res_idx,
  output logic [rv32v_types_pkg::WORD_W-1:0]     res_data,
  output logic [7:0]                             res_be
);
  import rv32v_types_pkg::*;

  logic                  chunk_valid; // iota lanes hold a chunk.
  logic [WORD_IDX_W-1:0] word_cnt;    // next word index of this run.
  logic [CNT_W-1:0]      elem_cnt;    // elements already written.
  logic [CNT_W-1:0]      chunk_elems; // elements per word.
  logic [1:0]            esz_log;     // log2 of element size in bytes.
  logic [7:0]            be_next;

  assign chunk_valid = start && busy;

  always_comb begin
    case (sew)
      SEW32: begin
        chunk_elems = CNT_W'(2);
        esz_log     = 2'd2;
      end
      SEW16: begin
        chunk_elems = CNT_W'(4);
        esz_log     = 2'd1;
      end
      default: begin
        chunk_elems = CNT_W'(8);
        esz_log     = 2'd0;
      end
    endcase
  end

  // a byte is enabled when its element lies below vl.
  always_comb begin : be_build
    logic [2:0]     lane;
    logic [CNT_W:0] elem;
    for (int b = 0; b < 8; b++) begin
      lane       = 3'(b) >> esz_log;
      elem       = {1'b0, elem_cnt} + {{(CNT_W - 2){1'b0}}, lane};
      be_next[b] = elem < {1'b0, vl};
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      res_we   <= 1'b0;
      word_cnt <= '0;
      elem_cnt <= '0;
    end else begin
      res_we <= chunk_valid; // one write per chunk, one cycle late.
      if (!start) begin // fresh indexes for the next run.
        word_cnt <= '0;
        elem_cnt <= '0;
      end else if (chunk_valid) begin
        word_cnt <= word_cnt + WORD_IDX_W'(1);
        elem_cnt <= elem_cnt + chunk_elems;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (chunk_valid) begin
      res_idx  <= word_cnt;
      res_data <= {res1, res0}; // upper lanes in the high half.
      res_be   <= be_next;
    end
  end

  // the first element of every chunk is below vl.
  a_be_nonzero: assert property (@(posedge CLK) disable iff (!nRST)
    res_we |-> res_be != 8'h00);

endmodule

/* design/rv32v_types_pkg.sv */
// shared types and constants
// for the vector mask-subset unit

package rv32v_types_pkg;

  // element width encoding, as held in the sew register.
  typedef enum logic [1:0] {
    SEW8  = 2'd0, // 8-bit elements, 8 per word.
    SEW16 = 2'd1, // 16-bit elements, 4 per word.
    SEW32 = 2'd2  // 32-bit elements, 2 per word.
  } sew_t;

  // vector sizing.
  localparam int MASK_BITS  = 64; // largest vl, one mask bit per element.
  localparam int CNT_W      = 7;  // element counters, 0 to 64.

  // result word layout.
  localparam int WORD_W     = 64; // one result word per chunk.
  localparam int HALF_W     = 32; // each iota lane half.
  localparam int WORD_IDX_W = 5;  // 32 words at sew32.

  // register block.
  localparam int CFG_ADDR_W = 3;

  localparam logic [CFG_ADDR_W-1:0] REG_MASK_LO = 3'd0; // mask bits 31:0.
  localparam logic [CFG_ADDR_W-1:0] REG_MASK_HI = 3'd1; // mask bits 63:32.
  localparam logic [CFG_ADDR_W-1:0] REG_VL      = 3'd2; // vector length.
  localparam logic [CFG_ADDR_W-1:0] REG_SEW     = 3'd3; // element width.
  localparam logic [CFG_ADDR_W-1:0] REG_CTRL    = 3'd4; // write starts a run.
  localparam logic [CFG_ADDR_W-1:0] REG_STATUS  = 3'd5; // read only.

  // status word fields.
  localparam int ST_BUSY = 0; // run in progress.

endpackage

/* design/vmask_cfg_regs.sv */
// mask unit configuration registers

module vmask_cfg_regs (
  input  logic                                     CLK,
  input  logic                                     nRST,
  input  logic                                     cfg_we,
  input  logic [rv32v_types_pkg::CFG_ADDR_W-1:0]   cfg_addr,
  input  logic [31:0]                              cfg_wdata,
  input  logic                                     busy,
  output logic [31:0]                              cfg_rdata,
  output logic [rv32v_types_pkg::MASK_BITS-1:0]    mask_bits,
  output logic [rv32v_types_pkg::CNT_W-1:0]        vl,
  output logic [rv32v_types_pkg::CNT_W-1:0]        max,
  output rv32v_types_pkg::sew_t                    sew,
  output logic                                     start,
  output logic                                     done
);
  import rv32v_types_pkg::*;

  logic             wr_idle;    // write accepted, no run active.
  logic             run_end;    // iota datapath has finished.
  logic [CNT_W-1:0] vl_clamped; // incoming vl limited to 64.
  sew_t             sew_wr;     // incoming width, 3 folds to sew32.

  // round a length up to a whole number of chunks for the given width.
  function automatic logic [CNT_W-1:0] round_vl(input logic [CNT_W-1:0] len,
                                                input sew_t w);
    logic [CNT_W-1:0] r;
    case (w)
      SEW32:   r = (len + CNT_W'(1)) & ~CNT_W'(1); // 2 elements per chunk.
      SEW16:   r = (len + CNT_W'(3)) & ~CNT_W'(3); // 4 elements per chunk.
      default: r = (len + CNT_W'(7)) & ~CNT_W'(7); // 8 elements per chunk.
    endcase
    return r;
  endfunction

  assign wr_idle = cfg_we && !start;
  assign run_end = start && !busy;

  assign vl_clamped = (cfg_wdata > 32'(MASK_BITS)) ? CNT_W'(MASK_BITS)
                                                   : cfg_wdata[CNT_W-1:0];

  always_comb begin
    case (cfg_wdata[1:0])
      2'd0:    sew_wr = SEW8;
      2'd1:    sew_wr = SEW16;
      default: sew_wr = SEW32; // reserved code runs as sew32.
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mask_bits <= '0;
      vl        <= '0;
      max       <= '0;
      sew       <= SEW8;
      start     <= 1'b0;
      done      <= 1'b0;
    end else begin
      done <= run_end; // one cycle, start drops on the same edge.
      if (run_end) begin
        start <= 1'b0;
      end else if (wr_idle && cfg_addr == REG_CTRL) begin
        start <= 1'b1; // ctrl writes during a run fall through.
      end
      if (wr_idle) begin // config held stable for the run.
        case (cfg_addr)
          REG_MASK_LO: mask_bits[31:0]  <= cfg_wdata;
          REG_MASK_HI: mask_bits[63:32] <= cfg_wdata;
          REG_VL: begin
            vl  <= vl_clamped;
            max <= round_vl(vl_clamped, sew);
          end
          REG_SEW: begin
            sew <= sew_wr;
            max <= round_vl(vl, sew_wr); // keep max in step with width.
          end
          default: ;
        endcase
      end
    end
  end

  // register read port.
  always_comb begin
    cfg_rdata = '0;
    case (cfg_addr)
      REG_MASK_LO: cfg_rdata = mask_bits[31:0];
      REG_MASK_HI: cfg_rdata = mask_bits[63:32];
      REG_VL:      cfg_rdata = {{(32 - CNT_W){1'b0}}, vl};
      REG_SEW:     cfg_rdata = {30'b0, sew};
      REG_CTRL:    cfg_rdata = {31'b0, start};
      REG_STATUS:  cfg_rdata[ST_BUSY] = start || busy; // live run state.
      default:     cfg_rdata = '0;
    endcase
  end

  // no new run level right behind a done pulse.
  a_done_idle: assert property (@(posedge CLK) disable iff (!nRST)
    done |=> !start);

endmodule

/* design/vmask_unit.sv */
// vector mask-subset unit, viota.m

module vmask_unit (
  input  logic                                   CLK,
  input  logic                                   nRST,
  input  logic                                   cfg_we,
  input  logic [rv32v_types_pkg::CFG_ADDR_W-1:0] cfg_addr,
  input  logic [31:0]                            cfg_wdata,
  output logic [31:0]                            cfg_rdata,
  output logic                                   done,
  output logic                                   res_we,
  output logic [rv32v_types_pkg::WORD_IDX_W-1:0] res_idx,
  output logic [rv32v_types_pkg::WORD_W-1:0]     res_data,
  output logic [7:0]                             res_be
);
  import rv32v_types_pkg::*;

  logic [MASK_BITS-1:0] mask_bits; // run mask.
  logic [CNT_W-1:0]     vl;        // unrounded length, tail masking only.
  logic [CNT_W-1:0]     max;       // chunk aligned length.
  sew_t                 sew;
  logic                 start;     // run level.
  logic                 busy;      // chunk in flight.
  logic [HALF_W-1:0]    res0;      // low lanes.
  logic [HALF_W-1:0]    res1;      // high lanes.

  vmask_cfg_regs u_cfg (
    .CLK       (CLK),
    .nRST      (nRST),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .busy      (busy),
    .cfg_rdata (cfg_rdata),
    .mask_bits (mask_bits),
    .vl        (vl),
    .max       (max),
    .sew       (sew),
    .start     (start),
    .done      (done)
  );

  iota_logic u_iota (
    .CLK       (CLK),
    .nRST      (nRST),
    .start     (start),
    .mask_bits (mask_bits),
    .sew       (sew),
    .max       (max),
    .busy      (busy),
    .res0      (res0),
    .res1      (res1)
  );

  iota_result_writer u_writer (
    .CLK      (CLK),
    .nRST     (nRST),
    .start    (start),
    .busy     (busy),
    .sew      (sew),
    .vl       (vl),
    .res0     (res0),
    .res1     (res1),
    .res_we   (res_we),
    .res_idx  (res_idx),
    .res_data (res_data),
    .res_be   (res_be)
  );

endmodule

/* run.sh */
#!/bin/sh
# build and run the vmask_unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_vmask_unit -Mdir obj_dir -o sim_vmask \
  -f vmask_unit.f

./obj_dir/sim_vmask > sim.log
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "simulation reported a failing check"
  exit 1
fi

/* vmask_unit.f */
+incdir+bench
design/rv32v_types_pkg.sv
design/vmask_cfg_regs.sv
design/iota_logic.sv
design/iota_result_writer.sv
design/vmask_unit.sv
bench/tb_vmask_unit.sv
